// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := $(FLAGS) --binary
LINT_FLAGS := $(FLAGS) --lint-only
TOP        := video_out_tb
FILELIST   := video_out_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log
RUN_FLAGS  := +verilator+error+limit+100000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, the simulator exit code is not used
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/video_out_sva.sv
/* output checker for video_out_top, bound into the DUT from the testbench.
   a pixel is only checked once its palette entry has been written */
`timescale 1ns/1ps
`default_nettype none

module video_out_sva
  import video_pkg::*;
(
  input logic                clk,
  input logic                reset,
  input logic                vga_on, tv_blank, vga_blank, vga_line,
  input logic                tv_hires, vga_hires, tv_pix_stb, cram_we,
  input logic [1:0]          hires_sel,
  input logic [3:0]          palsel,
  input logic [7:0]          tv_pix, vga_pix, cram_addr,
  input logic [CRAM_W-1:0]   cram_wdata,
  input logic [COARSE_W-1:0] dac_red_lo, dac_red_hi, dac_grn_lo, dac_grn_hi,
  input logic [COARSE_W-1:0] dac_blu_lo, dac_blu_hi,
  input logic [COMP_W-1:0]   red_raw, grn_raw, blu_raw,
  input logic                dac_mode
);

  logic [CRAM_W-1:0]     shadow [0:CRAM_DEPTH-1];
  logic [CRAM_DEPTH-1:0] known = '0;
  logic [7:0]            tv_q;
  logic [1:0]            cnt;
  logic [7:0]            a1;
  logic                  b1;
  logic                  b2;
  logic                  k2;
  logic [1:0]            p1;
  logic [1:0]            p2;
  logic [1:0]            want_ph;
  logic [CRAM_W-1:0]     d2;
  logic [CRAM_W-1:0]     want;
  logic [11:0]           want_dac;
  logic                  chk = 1'b0;
  logic                  rst_q = 1'b0;

  // palette index: lores takes the byte, hires takes palsel and one nibble
  function automatic logic [7:0] pal_addr(
    input logic [7:0] p,
    input logic       hi,
    input logic       sel,
    input logic [3:0] ps
  );
    if (!hi)
      return p;
    return sel ? {ps, p[3:0]} : {ps, p[7:4]};
  endfunction

  // expected DAC value, sub-phase index is {phase, hi}
  function automatic logic [1:0] dac_val(
    input logic [4:0] c,
    input logic [1:0] ph,
    input logic       hi
  );
    logic [7:0] pat;
    pat = PWM_PATTERN[c[2:0]];
    if (pat[{ph, hi}] && c[4:3] != 2'd3)
      return c[4:3] + 2'd1;
    return c[4:3];
  endfunction

  // palette shadow from CPU writes
  always @(posedge clk)
  begin
    if (cram_we)
    begin
      shadow[cram_addr] <= cram_wdata;
      known[cram_addr]  <= 1'b1;
    end
  end

  always @(posedge clk)
  begin
    rst_q <= reset;
    tv_q  <= reset ? 8'd0 : (tv_pix_stb ? tv_pix : tv_q);
    cnt   <= reset ? 2'd0 : cnt + 2'd1;
    // stage 1, address from the active source
    if (vga_on)
      a1 <= pal_addr(vga_pix, vga_hires, hires_sel[0], palsel);
    else
      a1 <= pal_addr(tv_q, tv_hires, hires_sel[1], palsel);
    b1 <= !reset && (vga_on ? vga_blank : tv_blank);
    p1 <= reset ? 2'd0 : (vga_on ? {vga_line, cnt[0]} : cnt);
    // stage 2, old word on a same-cycle write
    d2 <= shadow[a1];
    k2 <= known[a1];
    b2 <= !reset && b1;
    p2 <= reset ? 2'd0 : p1;
    // stage 3
    chk     <= reset || k2;
    want    <= reset ? '0 : {d2[CRAM_W-1], b2 ? 15'd0 : d2[COLOR_W-1:0]};
    want_ph <= reset ? 2'd0 : p2;
  end

  assign want_dac = {dac_val(want[14:10], want_ph, 1'b0), dac_val(want[14:10], want_ph, 1'b1),
                     dac_val(want[9:5], want_ph, 1'b0), dac_val(want[9:5], want_ph, 1'b1),
                     dac_val(want[4:0], want_ph, 1'b0), dac_val(want[4:0], want_ph, 1'b1)};

  a_raw: assert property (@(posedge clk) chk |-> {dac_mode, red_raw, grn_raw, blu_raw} == want)
    else
    begin
      video_out_tb.assert_fails++;
      $error("FAIL {dac_mode,red_raw,grn_raw,blu_raw} got %h expected %h",
        $sampled({dac_mode, red_raw, grn_raw, blu_raw}), $sampled(want));
    end

  a_dac: assert property (@(posedge clk) chk |-> {dac_red_lo, dac_red_hi, dac_grn_lo,
                          dac_grn_hi, dac_blu_lo, dac_blu_hi} == want_dac)
    else
    begin
      video_out_tb.assert_fails++;
      $error("FAIL {dac_red,dac_grn,dac_blu lo/hi} got %h expected %h",
        $sampled({dac_red_lo, dac_red_hi, dac_grn_lo, dac_grn_hi, dac_blu_lo, dac_blu_hi}),
        $sampled(want_dac));
    end

  // coarse 3 stays at 3 in both sub-phases
  a_sat: assert property (@(posedge clk)
    (red_raw[4:3] != 2'd3 || {dac_red_lo, dac_red_hi} == 4'hF) &&
    (grn_raw[4:3] != 2'd3 || {dac_grn_lo, dac_grn_hi} == 4'hF) &&
    (blu_raw[4:3] != 2'd3 || {dac_blu_lo, dac_blu_hi} == 4'hF))
    else
    begin
      video_out_tb.assert_fails++;
      $error("FAIL {dac_red,dac_grn,dac_blu lo/hi} got %h for raw color %h, coarse 3 rose",
        $sampled({dac_red_lo, dac_red_hi, dac_grn_lo, dac_grn_hi, dac_blu_lo, dac_blu_hi}),
        $sampled({red_raw, grn_raw, blu_raw}));
    end

  a_rst: assert property (@(posedge clk) rst_q |-> {dac_red_lo, dac_red_hi, dac_grn_lo,
                          dac_grn_hi, dac_blu_lo, dac_blu_hi, red_raw, grn_raw, blu_raw,
                          dac_mode} == 28'd0)
    else
    begin
      video_out_tb.assert_fails++;
      $error("FAIL all outputs after reset got %h expected 0000000",
        $sampled({dac_red_lo, dac_red_hi, dac_grn_lo, dac_grn_hi, dac_blu_lo, dac_blu_hi,
                  red_raw, grn_raw, blu_raw, dac_mode}));
    end

endmodule

`default_nettype wire

// File: sim/video_out_tb.sv
/* stimulus for video_out_top, checked by the bound video_out_sva module.
   fixed xorshift seed, so every run replays the same palette and pixels */
`timescale 1ns/1ps
`default_nettype none

module video_out_tb
  import video_pkg::*;
();

  // reset 14, lores 516, hires 260, latch 132, blank 132, pwm 524, reset again 54
  localparam int TEST_CYCLES = 1632;

  logic                clk;
  logic                reset;
  logic                vga_on, tv_blank, vga_blank, vga_line;
  logic                tv_hires, vga_hires, tv_pix_stb, cram_we;
  logic [1:0]          hires_sel;
  logic [3:0]          palsel;
  logic [7:0]          tv_pix, vga_pix, cram_addr;
  logic [CRAM_W-1:0]   cram_wdata;
  logic [COARSE_W-1:0] dac_red_lo, dac_red_hi, dac_grn_lo, dac_grn_hi, dac_blu_lo, dac_blu_hi;
  logic [COMP_W-1:0]   red_raw, grn_raw, blu_raw;
  logic                dac_mode;

  int                assert_fails = 0;
  int                tests_run = 0;
  int                mark = 0;
  logic [31:0]       rng = 32'd51;
  logic [CRAM_W-1:0] pal [0:CRAM_DEPTH-1];

  video_out_top u_dut (.*);

  bind video_out_top video_out_sva u_sva (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // first palette entry with the DAC mode bit set
  function automatic logic [7:0] find_mode_entry();
    for (int a = 0; a < CRAM_DEPTH; a++)
      if (pal[a][CRAM_W-1])
        return a[7:0];
    return 8'd0;
  endfunction

  task automatic init_inputs();
    reset      = 1'b1;
    vga_on     = 1'b0;
    tv_blank   = 1'b0;
    vga_blank  = 1'b0;
    vga_line   = 1'b0;
    tv_hires   = 1'b0;
    vga_hires  = 1'b0;
    tv_pix_stb = 1'b0;
    cram_we    = 1'b0;
    hires_sel  = 2'd0;
    palsel     = 4'd0;
    tv_pix     = 8'd0;
    vga_pix    = 8'd0;
    cram_addr  = 8'd0;
    cram_wdata = '0;
  endtask

  // strobes last one cycle unless set again
  task automatic step_cycle();
    @(negedge clk);
    cram_we    = 1'b0;
    tv_pix_stb = 1'b0;
  endtask

  task automatic write_cram(input logic [7:0] addr, input logic [CRAM_W-1:0] data);
    cram_we    = 1'b1;
    cram_addr  = addr;
    cram_wdata = data;
    pal[addr]  = data;
  endtask

  // drain the 3-stage pipeline before counting
  task automatic close_test(input string name);
    repeat (4) step_cycle();
    $display("test %-12s %0d assertion failures", name, assert_fails - mark);
    mark = assert_fails;
    tests_run++;
  endtask

  initial
  begin : stimulus
    int          i;
    logic [31:0] r;
    logic [7:0]  hot;
    init_inputs();
    repeat (10) step_cycle();
    reset = 1'b0;
    close_test("reset_state");

    // palette load while sweeping VGA lores, then a clean sweep
    vga_on = 1'b1;
    for (i = 0; i < 512; i++)
    begin
      step_cycle();
      r = next_rand();
      if (i < 256)
        write_cram(i[7:0], r[CRAM_W-1:0]);
      vga_pix  = i[7:0];
      vga_line = r[20];
    end
    close_test("vga_lores");

    // VGA first with select bit 0, then TV with select bit 1
    vga_hires = 1'b1;
    tv_hires  = 1'b1;
    for (i = 0; i < 256; i++)
    begin
      step_cycle();
      r = next_rand();
      vga_on     = (i < 128);
      hires_sel  = {i[5], i[6]};
      palsel     = r[3:0];
      vga_pix    = r[11:4];
      tv_pix     = r[19:12];
      tv_pix_stb = 1'b1;
      vga_line   = r[20];
    end
    vga_hires = 1'b0;
    tv_hires  = 1'b0;
    close_test("hires");

    // tv_pix moves every cycle, strobe only every fourth
    vga_on = 1'b0;
    for (i = 0; i < 128; i++)
    begin
      step_cycle();
      r = next_rand();
      tv_pix     = r[7:0];
      vga_pix    = r[15:8];
      tv_pix_stb = (i[1:0] == 2'd0);
    end
    close_test("tv_latch");

    // active blank on, then only the inactive blank on, for each source
    hot = find_mode_entry();
    for (i = 0; i < 128; i++)
    begin
      step_cycle();
      r = next_rand();
      vga_on = ~i[6];
      if (vga_on)
      begin
        vga_blank = ~i[5];
        tv_blank  = i[5] | r[0];
      end
      else
      begin
        tv_blank  = ~i[5];
        vga_blank = i[5] | r[0];
      end
      vga_pix    = i[0] ? hot : r[15:8];
      tv_pix     = i[0] ? hot : r[23:16];
      tv_pix_stb = 1'b1;
    end
    tv_blank  = 1'b0;
    vga_blank = 1'b0;
    close_test("blanking");

    // saturating words written under a read of the same entry, then TV and VGA sweeps
    for (i = 0; i < 520; i++)
    begin
      step_cycle();
      r = next_rand();
      vga_on = (i < 8) || (i >= 264);
      if (i < 8)
        write_cram(8'hF8 + i[7:0], {r[15], 2'b11, r[2:0], 2'b11, r[5:3], 2'b11, r[8:6]});
      // the RAM reads this address one edge later, when the next entry is written
      vga_pix    = (i < 8) ? 8'hF9 + i[7:0] : i[7:0];
      vga_line   = i[3];
      tv_pix     = i[7:0];
      tv_pix_stb = 1'b1;
    end
    close_test("pwm_dither");

    // reset in the middle of random traffic
    for (i = 0; i < 50; i++)
    begin
      step_cycle();
      r = next_rand();
      reset      = (i >= 20) && (i < 30);
      vga_pix    = r[7:0];
      vga_on     = r[8];
      tv_pix     = r[16:9];
      tv_pix_stb = r[17];
      vga_line   = r[18];
    end
    close_test("reset_again");

    $display("%0d tests run, %0d assertion failures", tests_run, assert_fails);
    if (assert_fails == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial
  begin : watchdog
    #(TEST_CYCLES * 20 + 2000);
    $display("watchdog expired, the run did not finish within %0d cycles", TEST_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/color_ram.sv
/* 256 x 16 color RAM, one write port and one registered read port.
   read of an address written in the same cycle returns the old word */
`timescale 1ns/1ps
`default_nettype none

module color_ram
  import video_pkg::*;
(
  input  logic               clk,
  input  logic               we,
  input  logic [CRAM_AW-1:0] waddr,
  input  logic [CRAM_AW-1:0] raddr,
  input  logic [CRAM_W-1:0]  wdata,
  output logic [CRAM_W-1:0]  rdata
);

  // contents undefined until the CPU loads a palette
  logic [CRAM_W-1:0] mem [0:CRAM_DEPTH-1];

  // CPU side
  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  // pixel side
  always_ff @(posedge clk)
  begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: source/pwm_dither.sv
/* last stage: blanking and 5-to-2 bit PWM dither for two sub-phases per clock.
   coarse value 3 is never rounded up; dac_mode is not blanked */
`timescale 1ns/1ps
`default_nettype none

module pwm_dither
  import video_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [CRAM_W-1:0]   color,
  input  logic                blank,
  input  logic [1:0]          phase,
  output logic [COARSE_W-1:0] dac_red_lo,
  output logic [COARSE_W-1:0] dac_red_hi,
  output logic [COARSE_W-1:0] dac_grn_lo,
  output logic [COARSE_W-1:0] dac_grn_hi,
  output logic [COARSE_W-1:0] dac_blu_lo,
  output logic [COARSE_W-1:0] dac_blu_hi,
  output logic [COMP_W-1:0]   red_raw,
  output logic [COMP_W-1:0]   grn_raw,
  output logic [COMP_W-1:0]   blu_raw,
  output logic                dac_mode
);

  logic [COLOR_W-1:0] vpix;
  logic [COMP_W-1:0]  red;
  logic [COMP_W-1:0]  grn;
  logic [COMP_W-1:0]  blu;
  logic [2:0]         sub_lo;
  logic [2:0]         sub_hi;

  // one component at one sub-phase
  function automatic logic [COARSE_W-1:0] dither(
    input logic [COMP_W-1:0] comp,
    input logic [2:0]        sub
  );
    logic [COARSE_W-1:0] coarse;
    logic [FINE_W-1:0]   fine;
    logic                up;
    coarse = comp[COMP_W-1 -: COARSE_W];
    fine   = comp[FINE_W-1:0];
    up     = PWM_PATTERN[fine][sub] && (coarse != '1);
    return up ? coarse + 1'b1 : coarse;
  endfunction

  // blanked color, red in the top component
  assign vpix = blank ? '0 : color[COLOR_W-1:0];
  assign red  = vpix[3*COMP_W-1 -: COMP_W];
  assign grn  = vpix[2*COMP_W-1 -: COMP_W];
  assign blu  = vpix[COMP_W-1:0];

  // lo takes the even sub-phase, hi the odd one
  assign sub_lo = {phase, 1'b0};
  assign sub_hi = {phase, 1'b1};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dac_red_lo <= '0;
      dac_red_hi <= '0;
      dac_grn_lo <= '0;
      dac_grn_hi <= '0;
      dac_blu_lo <= '0;
      dac_blu_hi <= '0;
      red_raw    <= '0;
      grn_raw    <= '0;
      blu_raw    <= '0;
      dac_mode   <= 1'b0;
    end
    else
    begin
      dac_red_lo <= dither(red, sub_lo);
      dac_red_hi <= dither(red, sub_hi);
      dac_grn_lo <= dither(grn, sub_lo);
      dac_grn_hi <= dither(grn, sub_hi);
      dac_blu_lo <= dither(blu, sub_lo);
      dac_blu_hi <= dither(blu, sub_hi);
      red_raw    <= red;
      grn_raw    <= grn;
      blu_raw    <= blu;
      // mode bit passes through blanking
      dac_mode   <= color[CRAM_W-1];
    end
  end

endmodule

`default_nettype wire

// File: source/video_out_top.sv
/* video output stage: pixel code to palette lookup to dithered 2-bit DAC values.
   fixed 3-clock latency, no back-pressure; both DAC sub-phases come out per clock */
`timescale 1ns/1ps
`default_nettype none

module video_out_top
  import video_pkg::*;
(
  input  logic                clk,
  input  logic                reset,

  // source and mode controls
  input  logic                vga_on,
  input  logic                tv_blank,
  input  logic                vga_blank,
  input  logic                vga_line,
  input  logic                tv_hires,
  input  logic                vga_hires,
  input  logic                tv_pix_stb,
  input  logic [1:0]          hires_sel,
  input  logic [3:0]          palsel,
  input  logic [7:0]          tv_pix,
  input  logic [7:0]          vga_pix,

  // CPU write port
  input  logic                cram_we,
  input  logic [CRAM_AW-1:0]  cram_addr,
  input  logic [CRAM_W-1:0]   cram_wdata,

  // DAC sub-phase values
  output logic [COARSE_W-1:0] dac_red_lo,
  output logic [COARSE_W-1:0] dac_red_hi,
  output logic [COARSE_W-1:0] dac_grn_lo,
  output logic [COARSE_W-1:0] dac_grn_hi,
  output logic [COARSE_W-1:0] dac_blu_lo,
  output logic [COARSE_W-1:0] dac_blu_hi,

  // blanked color, undithered
  output logic [COMP_W-1:0]   red_raw,
  output logic [COMP_W-1:0]   grn_raw,
  output logic [COMP_W-1:0]   blu_raw,
  output logic                dac_mode
);

  logic [CRAM_AW-1:0] pix_addr;
  logic               blank_d;
  logic [1:0]         phase_d;
  logic [CRAM_W-1:0]  cram_q;

  video_src_ctrl u_src_ctrl (
    .clk        (clk),
    .reset      (reset),
    .vga_on     (vga_on),
    .tv_blank   (tv_blank),
    .vga_blank  (vga_blank),
    .vga_line   (vga_line),
    .tv_hires   (tv_hires),
    .vga_hires  (vga_hires),
    .tv_pix_stb (tv_pix_stb),
    .hires_sel  (hires_sel),
    .palsel     (palsel),
    .tv_pix     (tv_pix),
    .vga_pix    (vga_pix),
    .pix_addr   (pix_addr),
    .blank_d    (blank_d),
    .phase_d    (phase_d)
  );

  color_ram u_color_ram (
    .clk   (clk),
    .we    (cram_we),
    .waddr (cram_addr),
    .raddr (pix_addr),
    .wdata (cram_wdata),
    .rdata (cram_q)
  );

  pwm_dither u_pwm_dither (
    .clk        (clk),
    .reset      (reset),
    .color      (cram_q),
    .blank      (blank_d),
    .phase      (phase_d),
    .dac_red_lo (dac_red_lo),
    .dac_red_hi (dac_red_hi),
    .dac_grn_lo (dac_grn_lo),
    .dac_grn_hi (dac_grn_hi),
    .dac_blu_lo (dac_blu_lo),
    .dac_blu_hi (dac_blu_hi),
    .red_raw    (red_raw),
    .grn_raw    (grn_raw),
    .blu_raw    (blu_raw),
    .dac_mode   (dac_mode)
  );

endmodule

`default_nettype wire

// File: source/video_pkg.sv
/* widths and PWM patterns shared by the video output stage.
   component layout is fixed at 5 bits: 2 coarse DAC bits over 3 fine bits */
`default_nettype none

package video_pkg;

  // one color component and its split
  localparam int COMP_W   = 5;
  localparam int COARSE_W = 2;
  localparam int FINE_W   = 3;

  // full color is three components, red highest
  localparam int COLOR_W = 3 * COMP_W;

  // color RAM word carries the DAC mode bit on top of the color
  localparam int CRAM_W     = COLOR_W + 1;
  localparam int CRAM_DEPTH = 256;
  localparam int CRAM_AW    = $clog2(CRAM_DEPTH);

  // PWM patterns, one per fine intensity
  // bit p set: sub-phase p rounds the coarse value up
  // sub-phase index is {phase, lo/hi}, so 8 sub-phases per 4 clocks
  localparam logic [7:0] PWM_PATTERN [0:7] = '{
    8'h00,
    8'h01,
    8'h41,
    8'h45,
    8'hA5,
    8'hA7,
    8'hD7,
    8'hDF
  };

endpackage

`default_nettype wire

// File: source/video_src_ctrl.sv
/* first pipeline stage: TV latch, source select, palette address, PWM phase.
   blank and phase get one extra register to line up with color RAM read data */
`timescale 1ns/1ps
`default_nettype none

module video_src_ctrl
  import video_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               vga_on,
  input  logic               tv_blank,
  input  logic               vga_blank,
  input  logic               vga_line,
  input  logic               tv_hires,
  input  logic               vga_hires,
  input  logic               tv_pix_stb,
  input  logic [1:0]         hires_sel,
  input  logic [3:0]         palsel,
  input  logic [7:0]         tv_pix,
  input  logic [7:0]         vga_pix,
  output logic [CRAM_AW-1:0] pix_addr,
  output logic               blank_d,
  output logic [1:0]         phase_d
);

  logic [7:0]         tv_pix_q;
  logic [7:0]         pix;
  logic               nib_sel;
  logic               hires;
  logic               blank;
  logic [CRAM_AW-1:0] addr_next;
  logic [1:0]         ph_cnt;
  logic [1:0]         phase_next;
  logic               blank_q;
  logic [1:0]         phase_q;

  // TV pixel byte only valid on its strobe
  always_ff @(posedge clk)
  begin
    if (reset)
      tv_pix_q <= '0;
    else if (tv_pix_stb)
      tv_pix_q <= tv_pix;
  end

  // source mux
  // VGA uses select bit 0, TV uses bit 1
  always_comb
  begin
    pix     = vga_on ? vga_pix      : tv_pix_q;
    nib_sel = vga_on ? hires_sel[0] : hires_sel[1];
    hires   = vga_on ? vga_hires    : tv_hires;
    blank   = vga_on ? vga_blank    : tv_blank;
  end

  // hires: 16-color palette picked by palsel, nibble picks the entry
  always_comb
  begin
    if (hires)
      addr_next = {palsel, nib_sel ? pix[3:0] : pix[7:4]};
    else
      addr_next = pix;
  end

  // free-running phase counter
  always_ff @(posedge clk)
  begin
    if (reset)
      ph_cnt <= '0;
    else
      ph_cnt <= ph_cnt + 2'd1;
  end

  // in VGA mode the line parity replaces the upper phase bit,
  // so alternate lines use the other half of the pattern
  assign phase_next = {vga_on ? vga_line : ph_cnt[1], ph_cnt[0]};

  // RAM address register, feeds the RAM read directly
  always_ff @(posedge clk)
  begin
    pix_addr <= addr_next;
  end

  // blank and phase, two stages to match the RAM read
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      blank_q <= 1'b0;
      phase_q <= '0;
      blank_d <= 1'b0;
      phase_d <= '0;
    end
    else
    begin
      blank_q <= blank;
      phase_q <= phase_next;
      blank_d <= blank_q;
      phase_d <= phase_q;
    end
  end

endmodule

`default_nettype wire

// File: video_out_top.f
source/video_pkg.sv
source/video_src_ctrl.sv
source/color_ram.sv
source/pwm_dither.sv
source/video_out_top.sv
sim/video_out_sva.sv
sim/video_out_tb.sv
